/* design/n163_pkg.sv */
// package with bank types, register selectors and fixed address bits for the n163 mapper
package n163_pkg;

	// bank numbers
	typedef logic [5:0] prg_bank_t; // 8 KB units
	typedef logic [7:0] chr_bank_t; // 1 KB units

	// irq counter, bit 15 is the enable
	typedef logic [15:0] count_t;

	// E000-FFFF always maps here
	localparam prg_bank_t prg_fixed_bank = 6'b111111;

	// upper prg address bits for the 6000-7FFF work ram window
	localparam logic [8:0] wram_hi_bits = 9'b111100000;

	// upper chr address bits
	localparam logic [3:0] chr_hi_bits = 4'b1000;

	// cpu address bits [15:11] pick the register
	localparam int reg_sel_width = 5;

	localparam logic [reg_sel_width-1:0] irq_lo_sel   = 5'b01010; // 5000
	localparam logic [reg_sel_width-1:0] irq_hi_sel   = 5'b01011; // 5800
	localparam logic [reg_sel_width-1:0] prg_sel_e000 = 5'b11100;
	localparam logic [reg_sel_width-1:0] prg_sel_e800 = 5'b11101;
	localparam logic [reg_sel_width-1:0] prg_sel_f000 = 5'b11110;

	// chr0-chr7 then chr10-chr13
	localparam int chr_bank_count = 12;

endpackage

/* design/n163_bank_if.sv */
// interface carrying the bank register image from the register file to the mappers
interface n163_bank_if;
	import n163_pkg::*;

	prg_bank_t prg_bank8000;
	prg_bank_t prg_banka000;
	prg_bank_t prg_bankc000;
	chr_bank_t chr_bank [chr_bank_count]; // entries 8-11 are chr10-chr13
	logic [1:0] chr_en; // per pattern table, 0 lets E0-FF banks hit chr ram

	modport regs (
		output prg_bank8000,
		output prg_banka000,
		output prg_bankc000,
		output chr_bank,
		output chr_en
	);

	modport prg (
		input prg_bank8000,
		input prg_banka000,
		input prg_bankc000
	);

	modport chr (
		input chr_bank,
		input chr_en
	);

endinterface

/* design/n163_regs.sv */
// bank register file written from the cpu bus at 8000-F7FF
module n163_regs (
	input logic clk20,
	input logic reset,
	input logic ce,
	input logic prg_write,
	input logic [15:0] prg_ain,
	input logic [7:0] prg_din,
	n163_bank_if.regs banks
);
	import n163_pkg::*;

	logic [reg_sel_width-1:0] sel;
	logic wr_en;

	assign sel = prg_ain[15 -: reg_sel_width];
	assign wr_en = ce && prg_write;

	always_ff @(posedge clk20) begin
		if (reset) begin
			banks.prg_bank8000 <= '0;
			banks.prg_banka000 <= '0;
			banks.prg_bankc000 <= '0;
			banks.chr_en <= '0;
			for (int i = 0; i < chr_bank_count; i++) begin
				banks.chr_bank[i] <= '0;
			end
		end else if (wr_en) begin
			if (sel[4:3] == 2'b10) begin
				// 8000-BFFF, chr0-chr7 one per 2 KB
				banks.chr_bank[sel[2:0]] <= prg_din;
			end else if (sel[4:2] == 3'b110) begin
				// C000-DFFF, chr10-chr13
				banks.chr_bank[{2'b10, sel[1:0]}] <= prg_din;
			end else begin
				case (sel)
					prg_sel_e000: begin
						banks.prg_bank8000 <= prg_din[5:0];
					end
					prg_sel_e800: begin
						banks.prg_banka000 <= prg_din[5:0];
						banks.chr_en <= prg_din[7:6];
					end
					prg_sel_f000: begin
						banks.prg_bankc000 <= prg_din[5:0];
					end
					default: ; // F800 up is the sound port, not here
				endcase
			end
		end
	end

endmodule

/* design/n163_irq.sv */
// irq timer with byte loads at 5000/5800 and the timeout flag
module n163_irq (
	input logic clk20,
	input logic reset,
	input logic ce,
	input logic prg_write,
	input logic [15:0] prg_ain,
	input logic [7:0] prg_din,
	output n163_pkg::count_t count,
	output logic irq
);
	import n163_pkg::*;

	logic [reg_sel_width-1:0] sel;
	count_t count_next;
	logic countup;
	logic irq_access;

	assign sel = prg_ain[15 -: reg_sel_width];
	assign count_next = count + 1'b1;
	assign countup = count[15] & ~&count[14:0]; // stops at FFFF
	assign irq_access = sel[reg_sel_width-1:1] == irq_lo_sel[reg_sel_width-1:1]; // 5xxx

	always_ff @(posedge clk20) begin
		if (reset) begin
			count <= '0;
			irq <= 1'b0;
		end else if (ce) begin
			if (irq_access)
				irq <= 1'b0; // any access acks
			else if (count == 16'hFFFF)
				irq <= 1'b1;

			if (prg_write && sel == irq_lo_sel)
				count[7:0] <= prg_din;
			else if (countup)
				count[7:0] <= count_next[7:0];

			if (prg_write && sel == irq_hi_sel)
				count[15:8] <= prg_din;
			else if (countup)
				count[15:8] <= count_next[15:8];
		end
	end

endmodule

/* design/n163_prg_map.sv */
// prg address translation, access allow, output enable and read data mux
module n163_prg_map (
	input logic [15:0] prg_ain,
	input logic prg_write,
	input logic [7:0] prg_din,
	input n163_pkg::count_t count,
	n163_bank_if.prg banks,
	output logic [21:0] prg_aout,
	output logic prg_allow,
	output logic prg_oe,
	output logic [7:0] prg_dout
);
	import n163_pkg::*;

	logic [reg_sel_width-1:0] sel;
	logic is_wram;
	logic is_reg;
	prg_bank_t bank;
	prg_bank_t bank_masked;

	assign sel = prg_ain[15 -: reg_sel_width];
	assign is_wram = prg_ain[15:13] == 3'b011;
	assign is_reg = prg_ain[15:12] == 4'b0101; // irq counter ports

	always_comb begin
		case (prg_ain[14:13])
			2'd0: bank = banks.prg_bank8000;
			2'd1: bank = banks.prg_banka000;
			2'd2: bank = banks.prg_bankc000;
			default: bank = prg_fixed_bank;
		endcase
	end

	// low two bank bits only count from 8000 up
	assign bank_masked = bank & {4'b1111, {2{prg_ain[15]}}};

	assign prg_aout = is_wram ? {wram_hi_bits, prg_ain[12:0]}
		: {3'b000, bank_masked, prg_ain[12:0]};

	assign prg_allow = (prg_ain[15] && !prg_write) || is_wram;
	assign prg_oe = !prg_write && (is_reg || is_wram || prg_ain[15]);

	always_comb begin
		case (sel)
			irq_lo_sel: prg_dout = count[7:0];
			irq_hi_sel: prg_dout = count[15:8];
			default: prg_dout = prg_din;
		endcase
	end

endmodule

/* design/n163_chr_map.sv */
// chr bank select, ciram and chr ram decode, nametable a10
module n163_chr_map (
	input logic [13:0] chr_ain,
	input logic chr_read,
	input logic chr_write,
	n163_bank_if.chr banks,
	output logic [21:0] chr_aout,
	output logic chr_allow,
	output logic chr_oe,
	output logic vram_ce,
	output logic vram_a10
);
	import n163_pkg::*;

	chr_bank_t bank;
	logic en_bit;
	logic ram_sel;
	logic nt_bank;

	// 0000-1FFF uses chr0-chr7, 2000-3FFF repeats chr10-chr13
	always_comb begin
		if (!chr_ain[13])
			bank = banks.chr_bank[chr_ain[12:10]];
		else
			bank = banks.chr_bank[{2'b10, chr_ain[11:10]}];
	end

	assign chr_aout = {chr_hi_bits, bank, chr_ain[9:0]};
	assign vram_a10 = chr_aout[10];

	assign nt_bank = &bank[7:5]; // E0-FF
	assign en_bit = chr_ain[12] ? banks.chr_en[1] : banks.chr_en[0];
	assign ram_sel = !en_bit && nt_bank;

	always_comb begin
		if (!chr_ain[13]) begin
			// pattern tables
			vram_ce = ram_sel;
			chr_oe = chr_read;
			chr_allow = chr_write && ram_sel;
		end else begin
			// nametables, E0-FF goes to ciram
			vram_ce = nt_bank;
			chr_oe = chr_read && !nt_bank;
			chr_allow = chr_write && ram_sel && !nt_bank;
		end
	end

endmodule

/* design/n163_mapper.sv */
// n163 mapper top level joining register file, irq timer and the prg and chr mappers
module n163_mapper (
	input logic clk20,
	input logic reset,
	input logic ce,
	input logic prg_read, // reads are qualified by !prg_write
	input logic prg_write,
	input logic [15:0] prg_ain,
	input logic [7:0] prg_din,
	output logic [7:0] prg_dout,
	output logic prg_oe,
	output logic prg_allow,
	output logic [21:0] prg_aout,
	input logic [13:0] chr_ain,
	input logic chr_read,
	input logic chr_write,
	output logic [21:0] chr_aout,
	output logic chr_allow,
	output logic chr_oe,
	output logic vram_ce,
	output logic vram_a10,
	output logic irq
);
	import n163_pkg::*;

	count_t count;

	n163_bank_if banks ();

	n163_regs regs_inst (
		.clk20     (clk20),
		.reset     (reset),
		.ce        (ce),
		.prg_write (prg_write),
		.prg_ain   (prg_ain),
		.prg_din   (prg_din),
		.banks     (banks.regs)
	);

	n163_irq irq_inst (
		.clk20     (clk20),
		.reset     (reset),
		.ce        (ce),
		.prg_write (prg_write),
		.prg_ain   (prg_ain),
		.prg_din   (prg_din),
		.count     (count),
		.irq       (irq)
	);

	// cpu side
	n163_prg_map prg_map_inst (
		.prg_ain   (prg_ain),
		.prg_write (prg_write),
		.prg_din   (prg_din),
		.count     (count),
		.banks     (banks.prg),
		.prg_aout  (prg_aout),
		.prg_allow (prg_allow),
		.prg_oe    (prg_oe),
		.prg_dout  (prg_dout)
	);

	// ppu side
	n163_chr_map chr_map_inst (
		.chr_ain   (chr_ain),
		.chr_read  (chr_read),
		.chr_write (chr_write),
		.banks     (banks.chr),
		.chr_aout  (chr_aout),
		.chr_allow (chr_allow),
		.chr_oe    (chr_oe),
		.vram_ce   (vram_ce),
		.vram_a10  (vram_a10)
	);

endmodule

/* test/n163_checker.sv */
// reference model of the n163 bank registers and irq timer, compared with the dut every cycle
module n163_checker (
	input logic clk20,
	input logic reset,
	input logic ce,
	input logic prg_write,
	input logic [15:0] prg_ain,
	input logic [7:0] prg_din,
	input logic [7:0] prg_dout,
	input logic prg_oe,
	input logic prg_allow,
	input logic [21:0] prg_aout,
	input logic [13:0] chr_ain,
	input logic chr_read,
	input logic chr_write,
	input logic [21:0] chr_aout,
	input logic chr_allow,
	input logic chr_oe,
	input logic vram_ce,
	input logic vram_a10,
	input logic irq,
	output int error_count
);
	logic [5:0] m_prg8000;
	logic [5:0] m_prga000;
	logic [5:0] m_prgc000;
	logic [7:0] m_chr [12]; // chr0-chr7, then chr10-chr13
	logic [1:0] m_chr_en;
	logic [15:0] m_count;
	logic m_irq;
	int errors = 0;

	logic in_wram;
	logic in_irq_port;
	logic [5:0] slot_bank;
	logic [21:0] exp_prg_aout;
	logic exp_prg_allow;
	logic exp_prg_oe;
	logic [7:0] exp_prg_dout;
	logic [3:0] chr_idx;
	logic [7:0] chr_bank_val;
	logic nt_hit;
	logic ram_hit;
	logic [21:0] exp_chr_aout;
	logic exp_vram_ce;
	logic exp_chr_oe;
	logic exp_chr_allow;
	logic [3:0] wr_idx;
	logic counting;
	logic [15:0] next_count;

	assign error_count = errors;

	always_comb begin
		in_wram = prg_ain >= 16'h6000 && prg_ain <= 16'h7FFF;
		in_irq_port = prg_ain >= 16'h5000 && prg_ain <= 16'h5FFF;
		case (prg_ain[14:13])
			2'd0: slot_bank = m_prg8000;
			2'd1: slot_bank = m_prga000;
			2'd2: slot_bank = m_prgc000;
			default: slot_bank = 6'h3F; // fixed last bank
		endcase
		if (prg_ain < 16'h8000)
			slot_bank[1:0] = 2'b00;
		exp_prg_aout = in_wram ? {9'h1E0, prg_ain[12:0]} : {3'b000, slot_bank, prg_ain[12:0]};
		exp_prg_allow = (prg_ain >= 16'h8000 && !prg_write) || in_wram;
		exp_prg_oe = !prg_write && (in_irq_port || in_wram || prg_ain >= 16'h8000);
		if (prg_ain >= 16'h5000 && prg_ain < 16'h5800)
			exp_prg_dout = m_count[7:0];
		else if (in_irq_port)
			exp_prg_dout = m_count[15:8];
		else
			exp_prg_dout = prg_din;
	end

	always_comb begin
		if (chr_ain[13:10] < 4'd8)
			chr_idx = chr_ain[13:10];
		else
			chr_idx = 4'd8 + {2'b00, chr_ain[11:10]}; // upper slots repeat chr10-chr13
		chr_bank_val = m_chr[chr_idx];
		exp_chr_aout = {4'b1000, chr_bank_val, chr_ain[9:0]};
		nt_hit = chr_bank_val >= 8'hE0;
		ram_hit = nt_hit && !m_chr_en[chr_ain[12]];
		if (chr_ain < 14'h2000) begin
			exp_vram_ce = ram_hit;
			exp_chr_oe = chr_read;
			exp_chr_allow = chr_write && ram_hit;
		end else begin
			exp_vram_ce = nt_hit;
			exp_chr_oe = chr_read && !nt_hit;
			exp_chr_allow = chr_write && ram_hit && !nt_hit;
		end
	end

	assign wr_idx = 4'((prg_ain - 16'h8000) >> 11); // only used for 8000-DFFF
	assign counting = m_count[15] && m_count[14:0] != 15'h7FFF;
	assign next_count = m_count + 16'd1;

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s at %0t expected %h got %h", name, $time, exp, got);
		end
	endtask

	always @(posedge clk20) begin
		if (reset) begin
			m_prg8000 <= '0;
			m_prga000 <= '0;
			m_prgc000 <= '0;
			m_chr_en <= '0;
			m_count <= '0;
			m_irq <= 1'b0;
			for (int i = 0; i < 12; i++)
				m_chr[i] <= '0;
		end else begin
			compare("prg_aout", 32'(exp_prg_aout), 32'(prg_aout));
			compare("prg_allow", 32'(exp_prg_allow), 32'(prg_allow));
			compare("prg_oe", 32'(exp_prg_oe), 32'(prg_oe));
			compare("prg_dout", 32'(exp_prg_dout), 32'(prg_dout));
			compare("chr_aout", 32'(exp_chr_aout), 32'(chr_aout));
			compare("vram_a10", 32'(chr_bank_val[0]), 32'(vram_a10));
			compare("vram_ce", 32'(exp_vram_ce), 32'(vram_ce));
			compare("chr_oe", 32'(exp_chr_oe), 32'(chr_oe));
			compare("chr_allow", 32'(exp_chr_allow), 32'(chr_allow));
			compare("irq", 32'(m_irq), 32'(irq));
			if (ce) begin
				if (prg_write && prg_ain >= 16'h8000 && prg_ain < 16'hE000)
					m_chr[wr_idx] <= prg_din;
				else if (prg_write && prg_ain >= 16'hE000 && prg_ain < 16'hE800)
					m_prg8000 <= prg_din[5:0];
				else if (prg_write && prg_ain >= 16'hE800 && prg_ain < 16'hF000) begin
					m_prga000 <= prg_din[5:0];
					m_chr_en <= prg_din[7:6];
				end else if (prg_write && prg_ain >= 16'hF000 && prg_ain < 16'hF800)
					m_prgc000 <= prg_din[5:0];

				if (prg_write && prg_ain >= 16'h5000 && prg_ain < 16'h5800)
					m_count[7:0] <= prg_din;
				else if (counting)
					m_count[7:0] <= next_count[7:0];
				if (prg_write && prg_ain >= 16'h5800 && prg_ain < 16'h6000)
					m_count[15:8] <= prg_din;
				else if (counting)
					m_count[15:8] <= next_count[15:8];

				if (in_irq_port)
					m_irq <= 1'b0; // ack wins over a new timeout
				else if (m_count == 16'hFFFF)
					m_irq <= 1'b1;
			end
		end
	end

endmodule

/* test/n163_tb.sv */
// testbench top with clock, reset, seeded random cpu and ppu stimulus, watchdog and dut
module n163_tb;
	localparam int clk_period = 100;
	localparam int reset_cycles = 8;
	localparam int reset_len = 64;
	localparam int prg_len = 400;
	localparam int chr_len = 400;
	localparam int decode_len = 400;
	localparam int irq_rounds = 4;
	localparam int irq_wait = 400;
	localparam int irq_round_len = irq_wait + 20;
	localparam int ignore_len = 300;
	localparam int watchdog_cycles = reset_cycles + reset_len + prg_len + chr_len + decode_len
		+ irq_rounds * irq_round_len + ignore_len + 500;

	logic clk20;
	logic reset;
	logic ce;
	logic prg_read;
	logic prg_write;
	logic [15:0] prg_ain;
	logic [7:0] prg_din;
	logic [7:0] prg_dout;
	logic prg_oe;
	logic prg_allow;
	logic [21:0] prg_aout;
	logic [13:0] chr_ain;
	logic chr_read;
	logic chr_write;
	logic [21:0] chr_aout;
	logic chr_allow;
	logic chr_oe;
	logic vram_ce;
	logic vram_a10;
	logic irq;

	integer seed = 32'h48ca;
	int checker_errors;
	int tb_errors = 0;
	int errors_before = 0;
	int failed_tests = 0;
	int total_errors;

	n163_mapper n163_mapper_inst (.*);

	n163_checker checker_inst (
		.clk20(clk20), .reset(reset), .ce(ce), .prg_write(prg_write),
		.prg_ain(prg_ain), .prg_din(prg_din), .prg_dout(prg_dout), .prg_oe(prg_oe),
		.prg_allow(prg_allow), .prg_aout(prg_aout), .chr_ain(chr_ain),
		.chr_read(chr_read), .chr_write(chr_write), .chr_aout(chr_aout),
		.chr_allow(chr_allow), .chr_oe(chr_oe), .vram_ce(vram_ce),
		.vram_a10(vram_a10), .irq(irq), .error_count(checker_errors)
	);

	initial begin
		clk20 = 1'b0;
		forever #(clk_period / 2) clk20 = ~clk20;
	end

	function automatic logic [31:0] next_rand();
		next_rand = $random(seed);
	endfunction

	// one cpu cycle on the falling edge with random ppu traffic
	task automatic bus_cycle(input logic [15:0] addr, input logic [7:0] data,
		input logic wr, input logic strobe);
		logic [31:0] r;
		@(negedge clk20);
		r = next_rand();
		prg_ain = addr;
		prg_din = data;
		prg_write = wr;
		prg_read = !wr;
		ce = strobe;
		chr_ain = r[13:0];
		chr_read = r[14];
		chr_write = r[15];
	endtask

	// random address inside the 2 KB step of one of the twelve chr registers
	function automatic logic [15:0] chr_reg_addr(input logic [31:0] r);
		int idx;
		idx = r[11:8] % 12;
		chr_reg_addr = 16'(32'h8000 + idx * 32'h800 + r[26:16]);
	endfunction

	task automatic finish_test(input int num, input string name);
		int now;
		bus_cycle(16'h8000, 8'h00, 1'b0, 1'b0); // lets the last cycle get checked
		now = checker_errors + tb_errors;
		if (now == errors_before) begin
			$display("test %0d %s: ok", num, name);
		end else begin
			failed_tests++;
			$display("test %0d %s: %0d errors", num, name, now - errors_before);
		end
		errors_before = now;
	endtask

	task automatic after_reset_reads();
		logic [31:0] r;
		for (int i = 0; i < reset_len; i++) begin
			r = next_rand();
			if (i % 4 == 3)
				bus_cycle({4'h5, r[11:0]}, 8'h00, 1'b0, r[16]); // counter read back
			else
				bus_cycle({1'b1, r[14:0]}, 8'h00, 1'b0, r[16]);
		end
	endtask

	task automatic prg_bank_writes();
		logic [31:0] r;
		logic [15:0] addr;
		for (int i = 0; i < prg_len; i++) begin
			r = next_rand();
			case (r[2:0])
				3'd0: addr = {5'b11100, r[18:8]};
				3'd1: addr = {5'b11101, r[18:8]};
				3'd2: addr = {5'b11110, r[18:8]};
				3'd3: addr = {3'b011, r[20:8]}; // work ram window
				default: addr = r[23:8];
			endcase
			bus_cycle(addr, r[31:24], r[2:0] < 3'd4, r[3] | r[4]);
		end
	endtask

	task automatic chr_bank_writes();
		logic [31:0] r;
		for (int i = 0; i < chr_len; i++) begin
			r = next_rand();
			if (r[1:0] != 2'b00)
				bus_cycle(chr_reg_addr(r), r[31:24], 1'b1, r[2] | r[3]);
			else
				bus_cycle({1'b1, r[22:8]}, 8'h00, 1'b0, r[2]);
		end
	endtask

	task automatic chr_decode_mix();
		logic [31:0] r;
		logic [7:0] data;
		for (int i = 0; i < decode_len; i++) begin
			r = next_rand();
			data = r[4] ? {3'b111, r[20:16]} : r[31:24]; // lean toward E0-FF
			case (r[1:0])
				2'd0: bus_cycle({5'b11101, r[18:8]}, r[31:24], 1'b1, 1'b1); // chr_en
				2'd3: bus_cycle({1'b1, r[22:8]}, 8'h00, 1'b0, r[2]);
				default: bus_cycle(chr_reg_addr(r), data, 1'b1, 1'b1);
			endcase
		end
	endtask

	task automatic irq_timer_rounds();
		logic [31:0] r;
		logic [15:0] start;
		int n;
		for (int k = 0; k < irq_rounds; k++) begin
			r = next_rand();
			start = (k % 2 == 1) ? {10'h3FF, r[5:0]} : {10'h200, r[5:0]};
			bus_cycle(16'h5800, 8'h00, 1'b1, 1'b1); // stop counting while loading
			bus_cycle({5'b01010, r[18:8]}, start[7:0], 1'b1, 1'b1);
			bus_cycle({5'b01011, r[18:8]}, start[15:8], 1'b1, 1'b1);
			bus_cycle(16'h5000, 8'h00, 1'b0, 1'b0);
			bus_cycle(16'h5800, 8'h00, 1'b0, 1'b0);
			n = 0;
			while (!irq && n < irq_wait) begin
				r = next_rand();
				bus_cycle({1'b1, r[14:0]}, r[23:16], 1'b0, r[24]);
				n++;
			end
			if (k % 2 == 1 && !irq) begin
				tb_errors++;
				$display("irq never rose within %0d cycles after loading %h", irq_wait, start);
			end else if (k % 2 == 0 && irq) begin
				tb_errors++;
				$display("[FAIL] irq counting up from %h expected %h got %h",
					start, 1'b0, irq);
			end
			repeat (4) bus_cycle(16'hC000, 8'h00, 1'b0, 1'b1); // irq holds
			r = next_rand();
			bus_cycle({4'h5, r[11:0]}, r[23:16], r[25], 1'b1); // ack by any 5xxx access
			bus_cycle(16'h8000, 8'h00, 1'b0, 1'b0);
			if (irq !== 1'b0) begin
				tb_errors++;
				$display("[FAIL] irq after 5xxx access expected %h got %h", 1'b0, irq);
			end
		end
	endtask

	task automatic ignored_writes();
		logic [31:0] r;
		for (int i = 0; i < ignore_len; i++) begin
			r = next_rand();
			if (r[0])
				bus_cycle(r[23:8], r[31:24], 1'b1, 1'b0);
			else if (r[1])
				bus_cycle({5'b11111, r[18:8]}, r[31:24], 1'b1, 1'b1); // F800 and up
			else
				bus_cycle({1'b1, r[22:8]}, 8'h00, 1'b0, r[2]);
		end
	endtask

	initial begin
		reset = 1'b1;
		ce = 1'b0;
		prg_read = 1'b0;
		prg_write = 1'b0;
		prg_ain = 16'h0000;
		prg_din = 8'h00;
		chr_ain = 14'h0000;
		chr_read = 1'b0;
		chr_write = 1'b0;
		repeat (reset_cycles) @(posedge clk20);
		@(negedge clk20);
		reset = 1'b0;
		after_reset_reads();
		finish_test(1, "after reset");
		prg_bank_writes();
		finish_test(2, "prg banks");
		chr_bank_writes();
		finish_test(3, "chr banks");
		chr_decode_mix();
		finish_test(4, "chr ram and nametable decode");
		irq_timer_rounds();
		finish_test(5, "irq timer");
		ignored_writes();
		finish_test(6, "ignored writes");
		total_errors = checker_errors + tb_errors;
		$display("tests 6, failed %0d, errors %0d", failed_tests, total_errors);
		if (total_errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		#(watchdog_cycles * clk_period);
		$display("watchdog expired after %0d cycles, run stopped", watchdog_cycles);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* verilog.f */
design/n163_pkg.sv
design/n163_bank_if.sv
design/n163_regs.sv
design/n163_irq.sv
design/n163_prg_map.sv
design/n163_chr_map.sv
design/n163_mapper.sv
test/n163_checker.sv
test/n163_tb.sv

/* Makefile */
LOG = sim.log

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f verilog.f --top-module n163_tb -Mdir obj_dir
	./obj_dir/Vn163_tb | tee $(LOG)
	@grep -qx "NO ERRORS" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: help test clean
